//--- compile.f
src/gpio_bus_pkg.sv
src/bus_cycle_ctrl.sv
src/gpo_register_bank.sv
src/gpi_input_port.sv
src/gpio_bus_slave.sv
tb/gpio_bus_checker.sv
tb/tb_gpio_bus_slave.sv

//--- tb/tb_gpio_bus_slave.sv
// GPIO bus slave testbench with clock, reset, falling-edge bus master and watchdog
`timescale 1ns/1ps

module tb_gpio_bus_slave;

	localparam int clk_period_ns      = 20;
	localparam int directed_requests  = 36;
	localparam int abandoned_requests = 8;
	localparam int random_requests    = 200;
	localparam int total_requests     = directed_requests + abandoned_requests +
		random_requests;
	// Handshake wait limit per request in cycles
	localparam int ready_wait_limit   = 16;

	logic                       BUS_agnt_vi;
	logic                       rst_n;
	logic                       valid;
	gpio_bus_pkg::bus_addr_t    addr;
	logic                       rnw;
	gpio_bus_pkg::bus_data_t    write_data;
	logic                       ready;
	logic                       error;
	gpio_bus_pkg::bus_data_t    read_data;
	gpio_bus_pkg::gpio_vector_t gp_ip;
	gpio_bus_pkg::gpio_vector_t gp_op;
	gpio_bus_pkg::gpio_strobe_t gp_op_valid;

	// Totals
	int value_errors;
	int protocol_errors;
	int requests_seen;
	int missed_ready;

	initial begin
		BUS_agnt_vi = 1'b0;
		forever #(clk_period_ns / 2) BUS_agnt_vi = ~BUS_agnt_vi;
	end

	gpio_bus_slave gpio_bus_slave_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n       (rst_n),
		.valid       (valid),
		.addr        (addr),
		.rnw         (rnw),
		.write_data  (write_data),
		.ready       (ready),
		.error       (error),
		.read_data   (read_data),
		.gp_ip       (gp_ip),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	gpio_bus_checker gpio_bus_checker_inst (
		.BUS_agnt_vi     (BUS_agnt_vi),
		.rst_n           (rst_n),
		.valid           (valid),
		.addr            (addr),
		.rnw             (rnw),
		.write_data      (write_data),
		.ready           (ready),
		.error           (error),
		.read_data       (read_data),
		.gp_ip           (gp_ip),
		.gp_op           (gp_op),
		.gp_op_valid     (gp_op_valid),
		.value_errors    (value_errors),
		.protocol_errors (protocol_errors),
		.requests_seen   (requests_seen)
	);

	// Watchdog allows twice eight cycles per request
	initial begin
		#(total_requests * 8 * clk_period_ns * 2);
		$display("Timeout: the run did not finish within %0d ns",
			total_requests * 8 * clk_period_ns * 2);
		$display("STATUS: FAIL");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Bus master tasks called right after a falling edge
	////////////////////////////////////////////////////////////

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge BUS_agnt_vi);
	endtask

	// Hold the request until ready, then keep two cycles of gap
	task automatic issue_request(input gpio_bus_pkg::bus_addr_t a, input logic is_read,
			input gpio_bus_pkg::bus_data_t wdata);
		int waited;
		valid      = 1'b1;
		addr       = a;
		rnw        = is_read;
		write_data = wdata;
		waited     = 0;
		do begin
			@(negedge BUS_agnt_vi);
			waited++;
		end while (ready !== 1'b1 && waited < ready_wait_limit);
		if (ready !== 1'b1) begin
			missed_ready++;
			$display("No ready within %0d cycles for address %h", ready_wait_limit, a);
		end
		valid = 1'b0;
		idle_cycles(2);
	endtask

	// Raise valid for a few cycles and withdraw it before the answer
	task automatic abandon_request(input gpio_bus_pkg::bus_addr_t a, input logic is_read,
			input gpio_bus_pkg::bus_data_t wdata, input int hold);
		valid      = 1'b1;
		addr       = a;
		rnw        = is_read;
		write_data = wdata;
		idle_cycles(hold);
		valid = 1'b0;
		idle_cycles(2);
	endtask

	// New pin value held three cycles so the synchronizer settles
	task automatic change_inputs(input gpio_bus_pkg::gpio_vector_t pins);
		gp_ip = pins;
		idle_cycles(3);
	endtask

	function automatic gpio_bus_pkg::gpio_vector_t random_vector();
		gpio_bus_pkg::gpio_vector_t v;
		for (int i = 0; i < gpio_bus_pkg::gpio_words; i++) begin
			v[i*32 +: 32] = $urandom;
		end
		return v;
	endfunction

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		gpio_bus_pkg::bus_addr_t a;
		int                      pick;
		rst_n        = 1'b0;
		valid        = 1'b0;
		addr         = '0;
		rnw          = 1'b0;
		write_data   = '0;
		gp_ip        = '0;
		missed_ready = 0;
		void'($urandom(58756));
		repeat (4) @(negedge BUS_agnt_vi);
		rst_n = 1'b1;
		idle_cycles(2);

		// Write each GPO word and read it back
		for (int i = 0; i < gpio_bus_pkg::gpio_words; i++) begin
			a = gpio_bus_pkg::gpio_base_addr + gpio_bus_pkg::gpo_offset + 4 * i;
			issue_request(a, 1'b0, $urandom);
			issue_request(a, 1'b1, '0);
		end

		// GPI words against held pins
		change_inputs(random_vector());
		for (int i = 0; i < gpio_bus_pkg::gpio_words; i++) begin
			issue_request(gpio_bus_pkg::gpio_base_addr + gpio_bus_pkg::gpi_offset + 4 * i,
				1'b1, '0);
		end

		// Error cases with GPI writes, out-of-window and unaligned addresses
		for (int i = 0; i < 4; i++) begin
			issue_request(gpio_bus_pkg::gpio_base_addr + gpio_bus_pkg::gpi_offset + 8 * i,
				1'b0, $urandom);
		end
		issue_request(gpio_bus_pkg::gpio_base_addr + 32'h40, 1'b0, $urandom);
		issue_request(gpio_bus_pkg::gpio_base_addr - 32'h4, 1'b0, $urandom);
		issue_request(32'h0000_0000, 1'b1, '0);
		issue_request(32'hFFFF_FFFC, 1'b1, '0);
		issue_request(gpio_bus_pkg::gpio_base_addr + 32'h01, 1'b0, $urandom);
		issue_request(gpio_bus_pkg::gpio_base_addr + 32'h06, 1'b0, $urandom);
		issue_request(gpio_bus_pkg::gpio_base_addr + 32'h22, 1'b1, '0);
		issue_request(gpio_bus_pkg::gpio_base_addr + 32'h3F, 1'b1, '0);

		// Withdrawn requests up to and including the respond state
		for (int i = 0; i < abandoned_requests; i++) begin
			abandon_request(gpio_bus_pkg::gpio_base_addr + gpio_bus_pkg::gpo_offset + 4 * i,
				1'(i % 2), $urandom, (i % 2) ? 1 + (i % 4) : 1 + (i % 3));
		end

		// Random mix with idle gaps and pin changes
		for (int n = 0; n < random_requests; n++) begin
			pick = $urandom_range(0, 9);
			if (pick <= 3) begin
				a = gpio_bus_pkg::gpio_base_addr + gpio_bus_pkg::gpo_offset +
					4 * $urandom_range(0, 7);
			end else if (pick <= 5) begin
				a = gpio_bus_pkg::gpio_base_addr + gpio_bus_pkg::gpi_offset +
					4 * $urandom_range(0, 7);
			end else if (pick == 6) begin
				a = $urandom;
			end else if (pick == 7) begin
				a = gpio_bus_pkg::gpio_base_addr + 4 * $urandom_range(0, 15) +
					$urandom_range(1, 3);
			end else begin
				// Around both window edges
				a = gpio_bus_pkg::gpio_base_addr - 32'h40 + 4 * $urandom_range(0, 47);
			end
			if ($urandom_range(0, 7) == 0) begin
				change_inputs(random_vector());
			end
			issue_request(a, 1'($urandom_range(0, 1)), $urandom);
			idle_cycles($urandom_range(0, 2));
		end

		idle_cycles(4);
		if (requests_seen != total_requests) begin
			$display("Request count mismatch: checker saw %0d, master issued %0d",
				requests_seen, total_requests);
		end
		$display("Requests %0d, value errors %0d, protocol errors %0d, missed ready %0d",
			requests_seen, value_errors, protocol_errors, missed_ready);
		if (value_errors == 0 && protocol_errors == 0 && missed_ready == 0 &&
				requests_seen == total_requests) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule : tb_gpio_bus_slave

//--- tb/gpio_bus_checker.sv
// GPIO bus checker that models the slave, samples every DUT port and compares
`timescale 1ns/1ps

module gpio_bus_checker (
	input  logic                           BUS_agnt_vi,
	input  logic                           rst_n,
	// Bus as seen on the DUT ports
	input  logic                           valid,
	input  gpio_bus_pkg::bus_addr_t        addr,
	input  logic                           rnw,
	input  gpio_bus_pkg::bus_data_t        write_data,
	input  logic                           ready,
	input  logic                           error,
	input  gpio_bus_pkg::bus_data_t        read_data,
	// GPIO pins
	input  gpio_bus_pkg::gpio_vector_t     gp_ip,
	input  gpio_bus_pkg::gpio_vector_t     gp_op,
	input  gpio_bus_pkg::gpio_strobe_t     gp_op_valid,
	// Running totals for the closing line
	output int                             value_errors,
	output int                             protocol_errors,
	output int                             requests_seen
);

	// Expected GPO words with word 0 in the low bits
	gpio_bus_pkg::gpio_vector_t shadow;

	// Request in flight
	logic                       busy;
	logic                       prev_valid;
	logic                       after_reset;
	int                         elapsed;
	gpio_bus_pkg::bus_addr_t    req_addr;
	logic                       req_rnw;

	// Expected answer of the request in flight
	int                         exp_latency;
	logic                       exp_error;
	gpio_bus_pkg::bus_data_t    exp_read_data;
	gpio_bus_pkg::gpio_strobe_t exp_strobe;
	gpio_bus_pkg::gpio_vector_t exp_shadow;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Answer of one request from the address map and handshake rules
	function automatic void expected_response(
		input  gpio_bus_pkg::bus_addr_t    a,
		input  logic                       is_read,
		input  gpio_bus_pkg::bus_data_t    wdata,
		input  gpio_bus_pkg::gpio_vector_t pins,
		input  gpio_bus_pkg::gpio_vector_t shadow_in,
		output int                         latency,
		output logic                       err,
		output gpio_bus_pkg::bus_data_t    rdata,
		output gpio_bus_pkg::gpio_strobe_t strobe,
		output gpio_bus_pkg::gpio_vector_t shadow_out
	);
		gpio_bus_pkg::bus_addr_t offset;
		logic                    aligned;
		logic                    hit_gpo;
		logic                    hit_gpi;
		int                      word;
		offset  = a - gpio_bus_pkg::gpio_base_addr;
		aligned = (a % 4) == 0;
		hit_gpo = aligned && (offset >= gpio_bus_pkg::gpo_offset) &&
			(offset < gpio_bus_pkg::gpo_offset + 4 * gpio_bus_pkg::gpio_words);
		hit_gpi = aligned && (offset >= gpio_bus_pkg::gpi_offset) &&
			(offset < gpio_bus_pkg::gpi_offset + 4 * gpio_bus_pkg::gpio_words);
		word    = hit_gpi ? int'((offset - gpio_bus_pkg::gpi_offset) / 4) :
			int'((offset - gpio_bus_pkg::gpo_offset) / 4);
		// Ready comes one edge after the last wait state
		latency = is_read ? gpio_bus_pkg::read_wait_cycles + 1 :
			gpio_bus_pkg::write_wait_cycles + 1;
		// GPI words are read-only
		err        = !(hit_gpo || (hit_gpi && is_read));
		rdata      = '0;
		strobe     = '0;
		shadow_out = shadow_in;
		if (!err && is_read) begin
			rdata = hit_gpo ? shadow_in[word*32 +: 32] : pins[word*32 +: 32];
		end else if (!err) begin
			shadow_out[word*32 +: 32] = wdata;
			strobe[word]              = 1'b1;
		end
	endfunction

	////////////////////////////////////////////////////////////
	// Compare helpers
	////////////////////////////////////////////////////////////

	task automatic compare_field(input string what, input logic [255:0] got,
			input logic [255:0] exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// Outside the ready cycle nothing moves
	task automatic check_quiet();
		compare_field("ready", ready, 1'b0);
		compare_field("error", error, 1'b0);
		compare_field("gp_op_valid", gp_op_valid, '0);
		compare_field("gp_op", gp_op, shadow);
	endtask

	task automatic check_answer();
		compare_field("error", error, exp_error);
		if (req_rnw && !exp_error) begin
			compare_field("read_data", read_data, exp_read_data);
		end
		compare_field("gp_op", gp_op, exp_shadow);
		compare_field("gp_op_valid", gp_op_valid, exp_strobe);
	endtask

	initial begin
		value_errors    = 0;
		protocol_errors = 0;
		requests_seen   = 0;
	end

	////////////////////////////////////////////////////////////
	// Sampling at the rising edge
	////////////////////////////////////////////////////////////

	always @(posedge BUS_agnt_vi) begin
		if (!rst_n) begin
			shadow      = '0;
			busy        = 1'b0;
			prev_valid  = 1'b0;
			after_reset = 1'b1;
		end else begin
			if (after_reset) begin
				// Values left by the reset
				compare_field("read_data after reset", read_data, '0);
				after_reset = 1'b0;
			end
			if (busy) begin
				elapsed++;
				if (elapsed == exp_latency + 1) begin
					// Ready set at edge N+latency shows in the next sample
					if (ready !== 1'b1) begin
						protocol_errors++;
						$display("Missing ready at %0t for the request to address %h",
							$time, req_addr);
					end else begin
						check_answer();
						shadow = exp_shadow;
					end
					busy = 1'b0;
				end else begin
					check_quiet();
					if (!valid) begin
						// Withdrawn request gets no answer and writes nothing
						busy = 1'b0;
					end
				end
			end else begin
				check_quiet();
				// Valid edge opens a new request
				if (valid && !prev_valid) begin
					req_addr = addr;
					req_rnw  = rnw;
					expected_response(addr, rnw, write_data, gp_ip, shadow, exp_latency,
						exp_error, exp_read_data, exp_strobe, exp_shadow);
					elapsed = 0;
					busy    = 1'b1;
					requests_seen++;
				end
			end
			prev_valid = valid;
		end
	end

endmodule : gpio_bus_checker

//--- src/gpio_bus_slave.sv
// GPIO bus slave top: cycle controller with GPO bank and GPI port as peer blocks
`timescale 1ns/1ps

module gpio_bus_slave (
	input  logic                               BUS_agnt_vi,
	input  logic                               rst_n,
	// Bus request
	input  logic                               valid,
	input  gpio_bus_pkg::bus_addr_t            addr,
	input  logic                               rnw,
	input  gpio_bus_pkg::bus_data_t            write_data,
	// Bus response
	output logic                               ready,
	output logic                               error,
	output gpio_bus_pkg::bus_data_t            read_data,
	// GPIO pins
	input  gpio_bus_pkg::gpio_vector_t         gp_ip,
	output gpio_bus_pkg::gpio_vector_t         gp_op,
	output gpio_bus_pkg::gpio_strobe_t         gp_op_valid
);

	////////////////////////////////////////////////////////////
	// Internal wires
	////////////////////////////////////////////////////////////

	logic                               gpo_wr_en;
	gpio_bus_pkg::gpio_word_index_t     word_index;
	gpio_bus_pkg::bus_data_t            wr_data;
	gpio_bus_pkg::bus_data_t            gpo_rd_word;
	gpio_bus_pkg::bus_data_t            gpi_rd_word;

	// Handshake, decode and read return
	bus_cycle_ctrl bus_cycle_ctrl_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n       (rst_n),
		.valid       (valid),
		.addr        (addr),
		.rnw         (rnw),
		.write_data  (write_data),
		.gpo_rd_word (gpo_rd_word),
		.gpi_rd_word (gpi_rd_word),
		.ready       (ready),
		.error       (error),
		.read_data   (read_data),
		.gpo_wr_en   (gpo_wr_en),
		.word_index  (word_index),
		.wr_data     (wr_data)
	);

	// Output words and strobes
	gpo_register_bank gpo_register_bank_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n       (rst_n),
		.gpo_wr_en   (gpo_wr_en),
		.word_index  (word_index),
		.wr_data     (wr_data),
		.gpo_rd_word (gpo_rd_word),
		.gp_op       (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	// Synchronized input pins
	gpi_input_port gpi_input_port_inst (
		.BUS_agnt_vi (BUS_agnt_vi),
		.rst_n       (rst_n),
		.gp_ip       (gp_ip),
		.word_index  (word_index),
		.gpi_rd_word (gpi_rd_word)
	);

endmodule : gpio_bus_slave

//--- src/gpi_input_port.sv
// GPI input port: two-flop synchronizer on the input pins and a word read port
`timescale 1ns/1ps

module gpi_input_port (
	input  logic                               BUS_agnt_vi,
	input  logic                               rst_n,
	// Asynchronous input pins
	input  gpio_bus_pkg::gpio_vector_t         gp_ip,
	// Word select from the cycle controller
	input  gpio_bus_pkg::gpio_word_index_t     word_index,
	// Selected synchronized word
	output gpio_bus_pkg::bus_data_t            gpi_rd_word
);

	// Synchronizer stages
	gpio_bus_pkg::gpio_vector_t gpi_meta;
	gpio_bus_pkg::gpio_vector_t gpi_sync;

	////////////////////////////////////////////////////////////
	// Two-stage synchronizer
	////////////////////////////////////////////////////////////

	// First stage may go metastable, second one settles it
	always_ff @(posedge BUS_agnt_vi or negedge rst_n) begin
		if (!rst_n) begin
			gpi_meta <= '0;
			gpi_sync <= '0;
		end else begin
			gpi_meta <= gp_ip;
			gpi_sync <= gpi_meta;
		end
	end

	////////////////////////////////////////////////////////////
	// Word select
	////////////////////////////////////////////////////////////

	// Slice 32 bits per word, word 0 in the low bits
	assign gpi_rd_word = gpi_sync[word_index*32 +: 32];

endmodule : gpi_input_port

//--- src/gpo_register_bank.sv
// GPO register bank: eight output words with per-word write strobes and readback
`timescale 1ns/1ps

module gpo_register_bank (
	input  logic                               BUS_agnt_vi,
	input  logic                               rst_n,
	// Write port from the cycle controller
	input  logic                               gpo_wr_en,
	input  gpio_bus_pkg::gpio_word_index_t     word_index,
	input  gpio_bus_pkg::bus_data_t            wr_data,
	// Readback of the indexed word
	output gpio_bus_pkg::bus_data_t            gpo_rd_word,
	// Output pins and strobes
	output gpio_bus_pkg::gpio_vector_t         gp_op,
	output gpio_bus_pkg::gpio_strobe_t         gp_op_valid
);

	// Storage, one entry per output word
	gpio_bus_pkg::bus_data_t gpo_mem [gpio_bus_pkg::gpio_words];

	// Next strobe pattern
	gpio_bus_pkg::gpio_strobe_t strobe_next;

	////////////////////////////////////////////////////////////
	// Word storage
	////////////////////////////////////////////////////////////

	// Outputs are visible pins, so they start from zero
	always_ff @(posedge BUS_agnt_vi or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < gpio_bus_pkg::gpio_words; i++) begin
				gpo_mem[i] <= '0;
			end
		end else if (gpo_wr_en) begin
			gpo_mem[word_index] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Write strobes
	////////////////////////////////////////////////////////////

	// One-hot bit of the written word
	always_comb begin
		if (gpo_wr_en) begin
			strobe_next = gpio_bus_pkg::gpio_strobe_t'(1) << word_index;
		end else begin
			strobe_next = '0;
		end
	end

	// Strobe lines up with the new word value
	always_ff @(posedge BUS_agnt_vi or negedge rst_n) begin
		if (!rst_n) begin
			gp_op_valid <= '0;
		end else begin
			gp_op_valid <= strobe_next;
		end
	end

	////////////////////////////////////////////////////////////
	// Pin vector and readback
	////////////////////////////////////////////////////////////

	// Word 0 sits in the low bits of the pin vector
	always_comb begin
		gp_op = '0;
		for (int i = 0; i < gpio_bus_pkg::gpio_words; i++) begin
			gp_op[i*32 +: 32] = gpo_mem[i];
		end
	end

	// Combinational read, the controller registers it
	assign gpo_rd_word = gpo_mem[word_index];

endmodule : gpo_register_bank

//--- src/bus_cycle_ctrl.sv
// Bus cycle controller: valid/ready handshake FSM, wait-state count, decode and read return
`timescale 1ns/1ps

module bus_cycle_ctrl (
	input  logic                               BUS_agnt_vi,
	input  logic                               rst_n,
	// Request side from the master
	input  logic                               valid,
	input  gpio_bus_pkg::bus_addr_t            addr,
	input  logic                               rnw,
	input  gpio_bus_pkg::bus_data_t            write_data,
	// Read words from the two register blocks
	input  gpio_bus_pkg::bus_data_t            gpo_rd_word,
	input  gpio_bus_pkg::bus_data_t            gpi_rd_word,
	// Response side to the master
	output logic                               ready,
	output logic                               error,
	output gpio_bus_pkg::bus_data_t            read_data,
	// Control toward the register blocks
	output logic                               gpo_wr_en,
	output gpio_bus_pkg::gpio_word_index_t     word_index,
	output gpio_bus_pkg::bus_data_t            wr_data
);

	// Handshake state and wait-state counter
	gpio_bus_pkg::bus_state_e  state;
	logic [1:0]                wait_cnt;
	logic [1:0]                wait_target;

	// Decode results
	gpio_bus_pkg::bus_region_e region;
	gpio_bus_pkg::bus_addr_t   win_offset;
	gpio_bus_pkg::bus_addr_t   word_offset;
	logic                      bad_access;
	gpio_bus_pkg::bus_data_t   rd_select;

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////

	always_comb begin
		// Offset from the window base, wraps for low addresses
		win_offset = addr - gpio_bus_pkg::gpio_base_addr;
		region     = gpio_bus_pkg::region_none;
		if (addr[1:0] != 2'b00) begin
			// Unaligned, never a register
			region = gpio_bus_pkg::region_none;
		end else if ((win_offset >= gpio_bus_pkg::gpo_offset) &&
				(win_offset < gpio_bus_pkg::gpo_offset + gpio_bus_pkg::gpio_bank_bytes)) begin
			region = gpio_bus_pkg::region_gpo;
		end else if ((win_offset >= gpio_bus_pkg::gpi_offset) &&
				(win_offset < gpio_bus_pkg::gpi_offset + gpio_bus_pkg::gpio_bank_bytes)) begin
			region = gpio_bus_pkg::region_gpi;
		end
	end

	// Word position inside the selected block
	always_comb begin
		if (region == gpio_bus_pkg::region_gpi) begin
			word_offset = win_offset - gpio_bus_pkg::gpi_offset;
		end else begin
			word_offset = win_offset - gpio_bus_pkg::gpo_offset;
		end
	end

	// Byte offset to word number, 4 bytes per word
	assign word_index = word_offset[4:2];

	// Out of window, unaligned, or a write to read-only inputs
	assign bad_access = (region == gpio_bus_pkg::region_none) ||
		((region == gpio_bus_pkg::region_gpi) && !rnw);

	// Shared read-return mux between the two peers
	assign rd_select = (region == gpio_bus_pkg::region_gpi) ? gpi_rd_word : gpo_rd_word;

	////////////////////////////////////////////////////////////
	// Wait-state target and write strobe
	////////////////////////////////////////////////////////////

	// Reads wait one state longer than writes
	always_comb begin
		if (rnw) begin
			wait_target = 2'(gpio_bus_pkg::read_wait_cycles);
		end else begin
			wait_target = 2'(gpio_bus_pkg::write_wait_cycles);
		end
	end

	// Write lands at the edge that raises ready
	assign gpo_wr_en = (state == gpio_bus_pkg::respond) && valid && !rnw && !bad_access;

	// Write data goes straight to the GPO bank
	assign wr_data = write_data;

	////////////////////////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge BUS_agnt_vi or negedge rst_n) begin
		if (!rst_n) begin
			state     <= gpio_bus_pkg::idle;
			wait_cnt  <= '0;
			ready     <= 1'b0;
			error     <= 1'b0;
			read_data <= '0;
		end else begin
			case (state)
				gpio_bus_pkg::idle: begin
					// Request edge counts as the first step
					if (valid) begin
						state    <= gpio_bus_pkg::wait_state;
						wait_cnt <= 2'd1;
					end
				end
				gpio_bus_pkg::wait_state: begin
					if (!valid) begin
						// Master gave up, drop the request
						state <= gpio_bus_pkg::idle;
					end else if (wait_cnt == wait_target) begin
						state <= gpio_bus_pkg::respond;
					end else begin
						wait_cnt <= wait_cnt + 2'd1;
					end
				end
				gpio_bus_pkg::respond: begin
					if (!valid) begin
						state <= gpio_bus_pkg::idle;
					end else begin
						ready <= 1'b1;
						error <= bad_access;
						// Only good reads carry data
						if (rnw && !bad_access) begin
							read_data <= rd_select;
						end else begin
							read_data <= '0;
						end
						state <= gpio_bus_pkg::release_gap;
					end
				end
				gpio_bus_pkg::release_gap: begin
					// Ready cycle is over, valid is ignored here
					ready     <= 1'b0;
					error     <= 1'b0;
					read_data <= '0;
					state     <= gpio_bus_pkg::idle;
				end
				default: begin
					state <= gpio_bus_pkg::idle;
				end
			endcase
		end
	end

endmodule : bus_cycle_ctrl

//--- src/gpio_bus_pkg.sv
// GPIO bus slave package: address map, data widths, wait-state counts and FSM/decode enums
package gpio_bus_pkg;

	////////////////////////////////////////////////////////////
	// Bus and GPIO types
	////////////////////////////////////////////////////////////

	// Bus address and data word
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// Full GPO or GPI pin vector, eight 32-bit words
	typedef logic [255:0] gpio_vector_t;

	// Selects one of the eight words in a block
	typedef logic [2:0] gpio_word_index_t;

	// One-hot write strobe, one bit per GPO word
	typedef logic [7:0] gpio_strobe_t;

	////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////

	// Words per register block
	localparam int gpio_words = 8;

	// Bytes per bus word
	localparam int gpio_word_bytes = 4;

	// Byte span of one register block
	localparam bus_addr_t gpio_bank_bytes = gpio_words * gpio_word_bytes;

	// Base of the 64-byte slave window
	localparam bus_addr_t gpio_base_addr = 32'h0100_0000;

	// Block offsets inside the window
	localparam bus_addr_t gpo_offset = 32'h0000_0000;
	localparam bus_addr_t gpi_offset = 32'h0000_0020;

	////////////////////////////////////////////////////////////
	// Handshake timing
	////////////////////////////////////////////////////////////

	// Wait states between request and answer
	localparam int write_wait_cycles = 2;
	localparam int read_wait_cycles  = 3;

	// Bus cycle controller states
	// release_gap is the forced idle cycle after ready
	typedef enum logic [1:0] {
		idle,
		wait_state,
		respond,
		release_gap
	} bus_state_e;

	// Address decode result
	typedef enum logic [1:0] {
		region_gpo,
		region_gpi,
		region_none
	} bus_region_e;

endpackage : gpio_bus_pkg
